/* rtl/fpu_pkg.sv */
// Shared widths, opcode enum, operand class and command, entry and result types
`default_nettype none

package fpu_pkg;

  // ========================================
  // Word and field widths
  // ========================================
  typedef logic [31:0] fp_word_t;    // IEEE single-precision word
  typedef logic [31:0] xlen_word_t;  // Integer register word
  typedef logic [7:0]  fp_exp_t;     // Biased exponent field
  typedef logic [22:0] fp_man_t;     // Mantissa field, bit 22 is the quiet bit

  // Canonical quiet NaN
  localparam fp_word_t CANON_NAN = 32'h7fc00000;

  localparam int FIFO_DEPTH_DEF = 4;  // Default entry buffer depth

  // ========================================
  // Opcodes
  // ========================================
  // Codes 11 to 15 are illegal
  typedef enum logic [3:0] {
    OP_SGNJ  = 4'd0,
    OP_SGNJN = 4'd1,
    OP_SGNJX = 4'd2,
    OP_MIN   = 4'd3,
    OP_MAX   = 4'd4,
    OP_FEQ   = 4'd5,
    OP_FLT   = 4'd6,
    OP_FLE   = 4'd7,
    OP_CLASS = 4'd8,
    OP_MV_XW = 4'd9,   // FP bits to integer
    OP_MV_WX = 4'd10   // Integer bits to FP
  } fp_op_t;

  // ========================================
  // Operand class and pipeline structs
  // ========================================
  typedef struct packed {
    logic sign;
    logic is_zero;
    logic is_subnormal;
    logic is_normal;
    logic is_inf;
    logic is_snan;
    logic is_qnan;
  } fp_class_t;

  typedef struct packed {
    fp_op_t     op;
    fp_word_t   a;
    fp_word_t   b;
    xlen_word_t x;   // Integer operand, used by FMV.W.X
  } fpu_cmd_t;

  // Decoded entry as stored in the FIFO
  typedef struct packed {
    fpu_cmd_t  cmd;
    fp_class_t cls_a;
    fp_class_t cls_b;
    logic      legal;  // Opcode within range
  } fpu_entry_t;

  typedef struct packed {
    fp_word_t   fp_result;
    xlen_word_t int_result;
    logic       flag_nv;   // Invalid operation
  } fpu_res_t;

endpackage

`default_nettype wire

/* rtl/fpu_cmd_intake.sv */
// Command producer with four-phase handshake, operand classification and FIFO push
`timescale 1ns/1ps
`default_nettype none

module fpu_cmd_intake
  import fpu_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  fpu_cmd_t   cmd,
  input  logic       cmd_req,
  output logic       cmd_ack,
  input  logic       full,
  output logic       push,
  output fpu_entry_t push_entry
);

  typedef enum logic {
    IDLE,       // Waiting for a new request
    WAIT_DROP   // Entry pushed, ack held until req falls
  } intake_state_t;

  intake_state_t state;

  // Sort one operand into its IEEE class
  function automatic fp_class_t classify(input fp_word_t w);
    fp_exp_t   exp_f;
    fp_man_t   man_f;
    fp_class_t c;
    exp_f = w[30:23];
    man_f = w[22:0];
    c.sign         = w[31];
    c.is_zero      = (exp_f == '0) && (man_f == '0);
    c.is_subnormal = (exp_f == '0) && (man_f != '0);
    c.is_normal    = (exp_f != '0) && (exp_f != '1);
    c.is_inf       = (exp_f == '1) && (man_f == '0);
    c.is_snan      = (exp_f == '1) && (man_f != '0) && !man_f[22];  // Quiet bit clear
    c.is_qnan      = (exp_f == '1) && man_f[22];
    return c;
  endfunction

  // ========================================
  // Handshake
  // ========================================
  // Take the command only when idle and there is room
  assign push    = (state == IDLE) && cmd_req && !full;
  assign cmd_ack = (state == WAIT_DROP);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (push) state <= WAIT_DROP;
        end
        WAIT_DROP: begin
          if (!cmd_req) state <= IDLE;   // Source let go, ack falls next cycle
        end
        default: state <= IDLE;
      endcase
    end
  end

  // ========================================
  // Entry decode
  // ========================================
  // Operands are classified once here so execute does not redo it
  always_comb begin
    push_entry.cmd   = cmd;
    push_entry.cls_a = classify(cmd.a);
    push_entry.cls_b = classify(cmd.b);
    push_entry.legal = (cmd.op <= OP_MV_WX);
  end

endmodule

`default_nettype wire

/* rtl/fpu_op_fifo.sv */
// Synchronous circular FIFO of decoded FPU entries
`timescale 1ns/1ps
`default_nettype none

module fpu_op_fifo
  import fpu_pkg::*;
#(
  parameter int DEPTH = FIFO_DEPTH_DEF   // Power of two
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       push,
  input  fpu_entry_t push_entry,
  input  logic       pop,
  output fpu_entry_t head,
  output logic       full,
  output logic       empty
);

  localparam int AW = $clog2(DEPTH);

  fpu_entry_t      mem [DEPTH];
  logic [AW-1:0]   wr_ptr;
  logic [AW-1:0]   rd_ptr;
  logic [AW:0]     count;    // Occupancy, one bit wider than the pointers
  logic            do_push;
  logic            do_pop;

  assign full    = (count == (AW+1)'(DEPTH));
  assign empty   = (count == '0);
  assign do_push = push && !full;   // Ignore push into a full buffer
  assign do_pop  = pop && !empty;
  assign head    = mem[rd_ptr];     // Valid whenever empty is low

  // Storage
  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= push_entry;
  end

  // Pointers and count, wrap is free with power-of-two depth
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;        // Both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/fpu_sign_minmax.sv */
// Combinational sign injection and FMIN/FMAX with invalid flag
`timescale 1ns/1ps
`default_nettype none

module fpu_sign_minmax
  import fpu_pkg::*;
(
  input  fpu_entry_t entry,
  output fp_word_t   result,
  output logic       flag_nv
);

  fp_word_t a;
  fp_word_t b;
  logic     a_nan;
  logic     b_nan;
  logic     a_lt_b;     // Ordered a < b, NaNs excluded elsewhere
  logic     inj_sign;
  logic     is_max;

  assign a      = entry.cmd.a;
  assign b      = entry.cmd.b;
  assign a_nan  = entry.cls_a.is_snan | entry.cls_a.is_qnan;
  assign b_nan  = entry.cls_b.is_snan | entry.cls_b.is_qnan;
  assign is_max = (entry.cmd.op == OP_MAX);

  // ========================================
  // Magnitude ordering
  // ========================================
  always_comb begin
    if (a[31] != b[31])
      a_lt_b = a[31];                 // Negative side is smaller, gives -0 < +0
    else if (a[31])
      a_lt_b = a[30:0] > b[30:0];     // Both negative, larger magnitude is smaller
    else
      a_lt_b = a[30:0] < b[30:0];
  end

  // Sign source for the three injection ops
  always_comb begin
    case (entry.cmd.op)
      OP_SGNJN: inj_sign = ~b[31];
      OP_SGNJX: inj_sign = a[31] ^ b[31];
      default:  inj_sign = b[31];     // FSGNJ
    endcase
  end

  // ========================================
  // Result select
  // ========================================
  always_comb begin
    result  = '0;
    flag_nv = 1'b0;
    case (entry.cmd.op)
      OP_SGNJ, OP_SGNJN, OP_SGNJX: begin
        result = {inj_sign, a[30:0]};  // Magnitude of a, never flags
      end
      OP_MIN, OP_MAX: begin
        flag_nv = entry.cls_a.is_snan | entry.cls_b.is_snan;
        if (a_nan && b_nan)
          result = CANON_NAN;
        else if (a_nan)
          result = b;                  // Non-NaN operand wins
        else if (b_nan)
          result = a;
        else if (is_max)
          result = a_lt_b ? b : a;
        else
          result = a_lt_b ? a : b;
      end
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/fpu_cmp_class.sv */
// Combinational FEQ/FLT/FLE compare and FCLASS with invalid flag
`timescale 1ns/1ps
`default_nettype none

module fpu_cmp_class
  import fpu_pkg::*;
(
  input  fpu_entry_t entry,
  output xlen_word_t result,
  output logic       flag_nv
);

  fp_word_t   a;
  fp_word_t   b;
  fp_class_t  ca;
  logic       any_nan;
  logic       any_snan;
  logic       both_zero;
  logic       eq;
  logic       lt;
  xlen_word_t class_word;

  assign a         = entry.cmd.a;
  assign b         = entry.cmd.b;
  assign ca        = entry.cls_a;
  assign any_snan  = ca.is_snan | entry.cls_b.is_snan;
  assign any_nan   = any_snan | ca.is_qnan | entry.cls_b.is_qnan;
  assign both_zero = ca.is_zero & entry.cls_b.is_zero;  // +0 and -0 are equal

  // ========================================
  // Ordering, valid only without NaNs
  // ========================================
  assign eq = (a == b) || both_zero;

  always_comb begin
    if (both_zero)
      lt = 1'b0;
    else if (a[31] != b[31])
      lt = a[31];
    else if (a[31])
      lt = a[30:0] > b[30:0];   // Both negative
    else
      lt = a[30:0] < b[30:0];
  end

  // FCLASS one-hot in RISC-V bit order
  always_comb begin
    class_word    = '0;
    class_word[0] =  ca.sign & ca.is_inf;
    class_word[1] =  ca.sign & ca.is_normal;
    class_word[2] =  ca.sign & ca.is_subnormal;
    class_word[3] =  ca.sign & ca.is_zero;
    class_word[4] = ~ca.sign & ca.is_zero;
    class_word[5] = ~ca.sign & ca.is_subnormal;
    class_word[6] = ~ca.sign & ca.is_normal;
    class_word[7] = ~ca.sign & ca.is_inf;
    class_word[8] =  ca.is_snan;           // Sign ignored for NaNs
    class_word[9] =  ca.is_qnan;
  end

  // ========================================
  // Result select
  // ========================================
  always_comb begin
    result  = '0;
    flag_nv = 1'b0;
    case (entry.cmd.op)
      OP_FEQ: begin
        result[0] = eq & ~any_nan;
        flag_nv   = any_snan;        // Quiet compare
      end
      OP_FLT: begin
        result[0] = lt & ~any_nan;
        flag_nv   = any_nan;         // Signaling compare
      end
      OP_FLE: begin
        result[0] = (lt | eq) & ~any_nan;
        flag_nv   = any_nan;
      end
      OP_CLASS: result = class_word;
      default:  result = '0;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/fpu_execute.sv */
// Result consumer with FIFO pop, unit result select and four-phase result handshake
`timescale 1ns/1ps
`default_nettype none

module fpu_execute
  import fpu_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  fpu_entry_t head,
  input  logic       empty,
  output logic       pop,
  output fpu_res_t   res,
  output logic       res_req,
  input  logic       res_ack
);

  typedef enum logic [1:0] {
    IDLE,       // Ready for the next entry
    HOLD,       // Result presented, waiting for ack
    WAIT_DROP   // Req dropped, waiting for ack to fall
  } exec_state_t;

  exec_state_t state;
  fp_word_t    sm_result;
  logic        sm_nv;
  xlen_word_t  cc_result;
  logic        cc_nv;
  fpu_res_t    res_next;

  // ========================================
  // Units
  // ========================================
  fpu_sign_minmax u_sign_minmax (
    .entry   (head),
    .result  (sm_result),
    .flag_nv (sm_nv)
  );

  fpu_cmp_class u_cmp_class (
    .entry   (head),
    .result  (cc_result),
    .flag_nv (cc_nv)
  );

  // Route the unit output by opcode, unused field stays zero
  always_comb begin
    res_next = '0;
    if (head.legal) begin
      case (head.cmd.op)
        OP_SGNJ, OP_SGNJN, OP_SGNJX, OP_MIN, OP_MAX: begin
          res_next.fp_result = sm_result;
          res_next.flag_nv   = sm_nv;
        end
        OP_FEQ, OP_FLT, OP_FLE, OP_CLASS: begin
          res_next.int_result = cc_result;
          res_next.flag_nv    = cc_nv;
        end
        OP_MV_XW: res_next.int_result = head.cmd.a;  // Raw bit copy
        OP_MV_WX: res_next.fp_result  = head.cmd.x;
        default:  res_next = '0;
      endcase
    end
  end

  // ========================================
  // Handshake
  // ========================================
  assign pop     = (state == IDLE) && !empty;
  assign res_req = (state == HOLD);

  // Result register, loaded with the pop
  always_ff @(posedge clk) begin
    if (pop) res <= res_next;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:      if (pop) state <= HOLD;
        HOLD:      if (res_ack) state <= WAIT_DROP;  // Req falls next cycle
        WAIT_DROP: if (!res_ack) state <= IDLE;
        default:   state <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/fpu_top.sv */
// FPU top level joining command intake, entry FIFO and execute stage
`timescale 1ns/1ps
`default_nettype none

module fpu_top
  import fpu_pkg::*;
#(
  parameter int DEPTH = FIFO_DEPTH_DEF   // Entry buffer depth
) (
  input  logic     clk,
  input  logic     rst,
  input  fpu_cmd_t cmd,
  input  logic     cmd_req,
  output logic     cmd_ack,
  output fpu_res_t res,
  output logic     res_req,
  input  logic     res_ack
);

  logic       push;
  logic       full;
  logic       pop;
  logic       empty;
  fpu_entry_t push_entry;
  fpu_entry_t head;

  // Producer side
  fpu_cmd_intake u_cmd_intake (
    .clk        (clk),
    .rst        (rst),
    .cmd        (cmd),
    .cmd_req    (cmd_req),
    .cmd_ack    (cmd_ack),
    .full       (full),
    .push       (push),
    .push_entry (push_entry)
  );

  fpu_op_fifo #(.DEPTH(DEPTH)) u_op_fifo (
    .clk        (clk),
    .rst        (rst),
    .push       (push),
    .push_entry (push_entry),
    .pop        (pop),
    .head       (head),
    .full       (full),
    .empty      (empty)
  );

  // Consumer side
  fpu_execute u_execute (
    .clk     (clk),
    .rst     (rst),
    .head    (head),
    .empty   (empty),
    .pop     (pop),
    .res     (res),
    .res_req (res_req),
    .res_ack (res_ack)
  );

endmodule

`default_nettype wire

/* include/fpu_tb_vectors.svh */
// Command table and expected results for the FPU testbench
`ifndef FPU_TB_VECTORS_SVH
`define FPU_TB_VECTORS_SVH

// One row, command in and expected result out
typedef struct packed {
  fpu_cmd_t cmd;
  fpu_res_t exp;
} tb_vec_t;

localparam int NUM_VECS = 39;

localparam tb_vec_t TB_VECS [NUM_VECS] = '{
  // Sign injection
  '{'{OP_SGNJ,  32'h3f800000, 32'hc0000000, 32'h0}, '{32'hbf800000, 32'h00000000, 1'b0}},
  '{'{OP_SGNJN, 32'h3f800000, 32'hc0000000, 32'h0}, '{32'h3f800000, 32'h00000000, 1'b0}},
  '{'{OP_SGNJX, 32'hbf800000, 32'hc0000000, 32'h0}, '{32'h3f800000, 32'h00000000, 1'b0}},
  '{'{OP_SGNJ,  32'h80000000, 32'h00000000, 32'h0}, '{32'h00000000, 32'h00000000, 1'b0}},
  '{'{OP_SGNJN, 32'h7fc00000, 32'h00000000, 32'h0}, '{32'hffc00000, 32'h00000000, 1'b0}},
  '{'{OP_SGNJX, 32'h7f800001, 32'hbf800000, 32'h0}, '{32'hff800001, 32'h00000000, 1'b0}},
  // Min and max
  '{'{OP_MIN,   32'h3f800000, 32'h40000000, 32'h0}, '{32'h3f800000, 32'h00000000, 1'b0}},
  '{'{OP_MAX,   32'hbf800000, 32'h40000000, 32'h0}, '{32'h40000000, 32'h00000000, 1'b0}},
  '{'{OP_MIN,   32'hbf800000, 32'hc0000000, 32'h0}, '{32'hc0000000, 32'h00000000, 1'b0}},
  '{'{OP_MIN,   32'h00000000, 32'h80000000, 32'h0}, '{32'h80000000, 32'h00000000, 1'b0}},
  '{'{OP_MAX,   32'h80000000, 32'h00000000, 32'h0}, '{32'h00000000, 32'h00000000, 1'b0}},
  '{'{OP_MIN,   32'h7fc00000, 32'hc0000000, 32'h0}, '{32'hc0000000, 32'h00000000, 1'b0}},
  '{'{OP_MAX,   32'h7fc00000, 32'hffc00000, 32'h0}, '{32'h7fc00000, 32'h00000000, 1'b0}},
  '{'{OP_MIN,   32'h7f800001, 32'h3f800000, 32'h0}, '{32'h3f800000, 32'h00000000, 1'b1}},
  '{'{OP_MAX,   32'h7f800001, 32'h7fc00000, 32'h0}, '{32'h7fc00000, 32'h00000000, 1'b1}},
  // Compares
  '{'{OP_FEQ,   32'h3f800000, 32'h3f800000, 32'h0}, '{32'h00000000, 32'h00000001, 1'b0}},
  '{'{OP_FEQ,   32'h00000000, 32'h80000000, 32'h0}, '{32'h00000000, 32'h00000001, 1'b0}},
  '{'{OP_FLT,   32'hbf800000, 32'h3f800000, 32'h0}, '{32'h00000000, 32'h00000001, 1'b0}},
  '{'{OP_FLT,   32'h80000000, 32'h00000000, 32'h0}, '{32'h00000000, 32'h00000000, 1'b0}},
  '{'{OP_FLE,   32'h80000000, 32'h00000000, 32'h0}, '{32'h00000000, 32'h00000001, 1'b0}},
  '{'{OP_FLE,   32'hc0000000, 32'hbf800000, 32'h0}, '{32'h00000000, 32'h00000001, 1'b0}},
  '{'{OP_FLT,   32'h40000000, 32'h3f800000, 32'h0}, '{32'h00000000, 32'h00000000, 1'b0}},
  '{'{OP_FEQ,   32'h7fc00000, 32'h3f800000, 32'h0}, '{32'h00000000, 32'h00000000, 1'b0}},
  '{'{OP_FEQ,   32'h7f800001, 32'h3f800000, 32'h0}, '{32'h00000000, 32'h00000000, 1'b1}},
  '{'{OP_FLT,   32'h7fc00000, 32'h3f800000, 32'h0}, '{32'h00000000, 32'h00000000, 1'b1}},
  '{'{OP_FLE,   32'h3f800000, 32'hffc00000, 32'h0}, '{32'h00000000, 32'h00000000, 1'b1}},
  // Classify, one row per class
  '{'{OP_CLASS, 32'hff800000, 32'h00000000, 32'h0}, '{32'h00000000, 32'h00000001, 1'b0}},
  '{'{OP_CLASS, 32'hbf800000, 32'h00000000, 32'h0}, '{32'h00000000, 32'h00000002, 1'b0}},
  '{'{OP_CLASS, 32'h80000001, 32'h00000000, 32'h0}, '{32'h00000000, 32'h00000004, 1'b0}},
  '{'{OP_CLASS, 32'h80000000, 32'h00000000, 32'h0}, '{32'h00000000, 32'h00000008, 1'b0}},
  '{'{OP_CLASS, 32'h00000000, 32'h00000000, 32'h0}, '{32'h00000000, 32'h00000010, 1'b0}},
  '{'{OP_CLASS, 32'h00000001, 32'h00000000, 32'h0}, '{32'h00000000, 32'h00000020, 1'b0}},
  '{'{OP_CLASS, 32'h3f800000, 32'h00000000, 32'h0}, '{32'h00000000, 32'h00000040, 1'b0}},
  '{'{OP_CLASS, 32'h7f800000, 32'h00000000, 32'h0}, '{32'h00000000, 32'h00000080, 1'b0}},
  '{'{OP_CLASS, 32'h7f800001, 32'h00000000, 32'h0}, '{32'h00000000, 32'h00000100, 1'b0}},
  '{'{OP_CLASS, 32'h7fc00000, 32'h00000000, 32'h0}, '{32'h00000000, 32'h00000200, 1'b0}},
  // Moves and an illegal opcode
  '{'{OP_MV_XW, 32'hc0490fdb, 32'h0, 32'h00000000}, '{32'h00000000, 32'hc0490fdb, 1'b0}},
  '{'{OP_MV_WX, 32'h00000000, 32'h0, 32'h12345678}, '{32'h12345678, 32'h00000000, 1'b0}},
  '{'{fp_op_t'(4'd12), 32'h7f800001, 32'h7fc00000, 32'h5}, '{32'h0, 32'h0, 1'b0}}
};

`endif

/* testbench/fpu_tb.sv */
// FPU testbench with clock, reset, command driver, result checker, xorshift and compare tasks
`timescale 1ns/1ps
`default_nettype none

module fpu_tb
  import fpu_pkg::*;
();

  `include "fpu_tb_vectors.svh"

  // ========================================
  // Constants and signals
  // ========================================
  localparam int DEPTH      = FIFO_DEPTH_DEF;
  localparam int WAIT_LIMIT = 200;           // Cycles per wait loop
  localparam int STALL_ROW  = 10;            // Row held back by the sink
  localparam int STALL_LEN  = 60;            // Long enough to fill the FIFO
  localparam logic [31:0] SEED = 32'h3e4c_54f8;

  logic     clk;
  logic     rst;
  fpu_cmd_t cmd;
  logic     cmd_req;
  logic     cmd_ack;
  fpu_res_t res;
  logic     res_req;
  logic     res_ack;

  int sent_cnt;       // Commands acknowledged by intake
  int done_cnt;       // Results fully handed over
  int max_in_flight;

  fpu_top #(.DEPTH(DEPTH)) u_fpu_top (
    .clk     (clk),
    .rst     (rst),
    .cmd     (cmd),
    .cmd_req (cmd_req),
    .cmd_ack (cmd_ack),
    .res     (res),
    .res_req (res_req),
    .res_ack (res_ack)
  );

  always #20 clk = ~clk;   // 40 ns period

  // Peak occupancy, counts change only on falling edges
  always @(posedge clk) begin
    if (sent_cnt - done_cnt > max_in_flight) max_in_flight = sent_cnt - done_cnt;
  end

  // ========================================
  // Helpers
  // ========================================
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "run aborted");
  endtask

  task automatic check_fp(input string name, input int row, input fp_word_t got,
                          input fp_word_t exp);
    if (got !== exp)
      abort_run($sformatf("FAIL %s (row %0d): got %h expected %h", name, row, got, exp));
  endtask

  task automatic check_int(input string name, input int row, input xlen_word_t got,
                           input xlen_word_t exp);
    if (got !== exp)
      abort_run($sformatf("FAIL %s (row %0d): got %h expected %h", name, row, got, exp));
  endtask

  task automatic check_flag(input string name, input int row, input logic got,
                            input logic exp);
    if (got !== exp)
      abort_run($sformatf("FAIL %s (row %0d): got %h expected %h", name, row, got, exp));
  endtask

  // ========================================
  // Command driver
  // ========================================
  task automatic drive_commands();
    logic [31:0] rng;
    logic [2:0]  gap;
    int          t;
    rng = SEED;
    for (int i = 0; i < NUM_VECS; i++) begin
      rng = xorshift32(rng);
      gap = rng[2:0];                        // 0 to 7 idle cycles
      repeat (gap) @(negedge clk);
      cmd     = TB_VECS[i].cmd;
      cmd_req = 1'b1;
      t = 0;
      while (!cmd_ack) begin               // Held off while the FIFO is full
        @(negedge clk);
        t++;
        if (t > WAIT_LIMIT) abort_run($sformatf("Timeout waiting for cmd_ack on row %0d", i));
      end
      sent_cnt++;
      cmd_req = 1'b0;
      t = 0;
      while (cmd_ack) begin
        @(negedge clk);
        t++;
        if (t > WAIT_LIMIT) abort_run($sformatf("cmd_ack never fell on row %0d", i));
      end
    end
  endtask

  // ========================================
  // Result checker
  // ========================================
  task automatic collect_results();
    logic [31:0] rng;
    logic [2:0]  delay;
    int          t;
    rng = ~SEED;   // Own stream, apart from the driver
    for (int i = 0; i < NUM_VECS; i++) begin
      t = 0;
      while (!res_req) begin
        @(negedge clk);
        t++;
        if (t > WAIT_LIMIT) abort_run($sformatf("Timeout waiting for res_req on row %0d", i));
      end
      // Results must arrive in table order
      check_fp("fp_result", i, res.fp_result, TB_VECS[i].exp.fp_result);
      check_int("int_result", i, res.int_result, TB_VECS[i].exp.int_result);
      check_flag("flag_nv", i, res.flag_nv, TB_VECS[i].exp.flag_nv);
      rng   = xorshift32(rng);
      delay = rng[2:0];
      if (i == STALL_ROW)
        repeat (STALL_LEN) @(negedge clk);  // Slow sink, back-pressure
      else
        repeat (delay) @(negedge clk);
      res_ack = 1'b1;
      t = 0;
      while (res_req) begin
        @(negedge clk);
        t++;
        if (t > WAIT_LIMIT) abort_run($sformatf("res_req never fell on row %0d", i));
      end
      res_ack = 1'b0;
      done_cnt++;
    end
  endtask

  // ========================================
  // Main sequence
  // ========================================
  initial begin
    clk           = 1'b0;
    rst           = 1'b1;
    cmd           = '0;
    cmd_req       = 1'b0;
    res_ack       = 1'b0;
    sent_cnt      = 0;
    done_cnt      = 0;
    max_in_flight = 0;
    repeat (2) @(negedge clk);   // Two rising edges in reset
    rst = 1'b0;
    check_flag("cmd_ack", -1, cmd_ack, 1'b0);
    check_flag("res_req", -1, res_req, 1'b0);
    fork
      drive_commands();
      collect_results();
    join
    // One entry held in execute plus a full FIFO
    if (max_in_flight < DEPTH + 1) begin
      abort_run($sformatf("FIFO never filled under back-pressure, peak in flight was %0d",
                          max_in_flight));
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+include
rtl/fpu_pkg.sv
rtl/fpu_cmd_intake.sv
rtl/fpu_op_fifo.sv
rtl/fpu_sign_minmax.sv
rtl/fpu_cmp_class.sv
rtl/fpu_execute.sv
rtl/fpu_top.sv
testbench/fpu_tb.sv

/* run.sh */
#!/bin/sh
# Build the FPU testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module fpu_tb -o fpu_sim \
  && ./obj_dir/fpu_sim \
  || { echo "Simulation run returned an error status"; exit 1; }

exit 0
